// ==== common/xfer_types_pkg.sv ====
// Types of the configuration words moved between the two clock domains.
// The word width is fixed here and is not a module parameter.
// Changing CFG_W resizes the interface, the crossing and the shadow register.

`default_nettype none

package xfer_types_pkg;

  // ----------------------------------------
  // Word width
  // ----------------------------------------

  // Bits in one configuration word
  localparam int CFG_W = 32;

  // ----------------------------------------
  // Vector types
  // ----------------------------------------

  // One configuration word as written on the source side
  // and as presented on the destination side
  typedef logic [CFG_W-1:0] cfg_word_t;

endpackage

`default_nettype wire

// ==== common/xfer_ctrl_pkg.sv ====
// Control definitions for the source-side coalescer and the crossing.
// The default synchronizer depth only takes effect where the top level is left at default.

`default_nettype none

package xfer_ctrl_pkg;

  // Coalescer states
  // CO_IDLE holds nothing, CO_LAUNCHED waits for the busy level to show,
  // CO_PEND keeps a newer word until the crossing is free
  typedef enum logic [1:0] {
    CO_IDLE     = 2'd0,
    CO_LAUNCHED = 2'd1,
    CO_PEND     = 2'd2
  } coalesce_state_t;

  // Flops per synchronizer chain, 2 or 3 are supported
  localparam int DEF_SYNC_STAGES = 2;

endpackage

`default_nettype wire

// ==== common/pulse_xfer_if.sv ====
// One word crossing between the source and destination clock domains.
// in_v and in_data belong to the source clock, out_v and out_data to the destination clock.
// req_active is a source-clock level. A strobe given while it is high is dropped.

`timescale 1ns/1ps
`default_nettype none

interface pulse_xfer_if;

  // ----------------------------------------
  // Source clock domain
  // ----------------------------------------
  logic                      in_v;
  xfer_types_pkg::cfg_word_t in_data;
  logic                      req_active;

  // ----------------------------------------
  // Destination clock domain
  // ----------------------------------------
  logic                      out_v;
  xfer_types_pkg::cfg_word_t out_data;

  // Producer of words in the source domain
  modport src (output in_v, output in_data, input req_active);

  // Consumer of delivered words in the destination domain
  modport dst (input out_v, input out_data);

  // The crossing itself sits between both sides
  modport xfer (input in_v, input in_data, output req_active, output out_v, output out_data);

endinterface

`default_nettype wire

// ==== hdl/sync_flops.sv ====
// Single-bit level synchronizer, a chain of STAGES flops clocked by clk.
// Only levels that are held for several clk cycles may pass through it.
// STAGES must be at least 2.

`timescale 1ns/1ps
`default_nettype none

module sync_flops #(
  parameter int STAGES = xfer_ctrl_pkg::DEF_SYNC_STAGES
) (
  input  logic clk,
  input  logic rst_n,
  input  logic d,
  output logic q
);

  // Shift chain, bit 0 samples the asynchronous input
  logic [STAGES-1:0] sync_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[STAGES-2:0], d};
    end
  end

  // The last stage is the only one safe to use in the clk domain
  assign q = sync_q[STAGES-1];

endmodule

`default_nettype wire

// ==== pulse_xfer/pulse_xfer_reg.sv ====
// Moves a one-cycle strobe and its data word from src_clk into dst_clk.
// Only one word is in flight at a time. A new strobe needs req_active to be low.
// out_data is not synchronized and relies on the held source register being stable.
// The two resets are expected to be released without any sequencing between them.

`timescale 1ns/1ps
`default_nettype none

module pulse_xfer_reg #(
  parameter int SYNC_STAGES = xfer_ctrl_pkg::DEF_SYNC_STAGES
) (
  input  logic         src_clk,
  input  logic         src_rst_n,
  input  logic         dst_clk,
  input  logic         dst_rst_n,
  pulse_xfer_if.xfer   xf
);

  // Source side state
  logic                      accept;
  logic                      req_q;
  logic                      req_d;
  logic                      active_q;
  logic                      active_d;
  xfer_types_pkg::cfg_word_t data_q;
  logic                      ack_sync;
  logic                      ack_sync_q;
  logic                      ack_re;
  logic                      ack_fe;

  // Destination side state
  logic                      req_sync;
  logic                      req_sync_q;
  logic                      req_re;
  logic                      req_fe;
  logic                      ack_q;
  logic                      ack_d;

  // ----------------------------------------
  // Source clock domain
  // ----------------------------------------

  // A strobe only counts while no transfer is active
  assign accept = xf.in_v & ~active_q;

  // The request drops once the destination has seen it rise
  assign req_d = (accept | req_q) & ~ack_re;

  // Active stays up until the acknowledge has fallen again, so the
  // full loop has closed before the next word may enter
  assign active_d = (accept | active_q) & ~ack_fe;

  assign ack_re = ack_sync & ~ack_sync_q;
  assign ack_fe = ~ack_sync & ack_sync_q;

  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      req_q      <= 1'b0;
      active_q   <= 1'b0;
      ack_sync_q <= 1'b0;
    end else begin
      req_q      <= req_d;
      active_q   <= active_d;
      ack_sync_q <= ack_sync;
    end
  end

  // Payload is held from acceptance until the loop closes
  always_ff @(posedge src_clk) begin
    if (accept) begin
      data_q <= xf.in_data;
    end
  end

  assign xf.req_active = active_q;

  // Request into the destination domain
  sync_flops #(.STAGES(SYNC_STAGES)) u_req_sync (
    .clk   (dst_clk),
    .rst_n (dst_rst_n),
    .d     (req_q),
    .q     (req_sync)
  );

  // ----------------------------------------
  // Destination clock domain
  // ----------------------------------------

  assign req_re = req_sync & ~req_sync_q;
  assign req_fe = ~req_sync & req_sync_q;

  // Acknowledge rises with the request and falls with it
  assign ack_d = (req_re | ack_q) & ~req_fe;

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      req_sync_q <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      req_sync_q <= req_sync;
      ack_q      <= ack_d;
    end
  end

  // The falling edge of the request marks delivery, one dst_clk cycle wide
  assign xf.out_v    = req_fe;
  assign xf.out_data = data_q;

  // Acknowledge back into the source domain
  sync_flops #(.STAGES(SYNC_STAGES)) u_ack_sync (
    .clk   (src_clk),
    .rst_n (src_rst_n),
    .d     (ack_q),
    .q     (ack_sync)
  );

endmodule

`default_nettype wire

// ==== hdl/write_coalescer.sv ====
// Source-side write stage in front of the crossing.
// Writes are never refused. While a word is in flight only the newest one is kept,
// so intermediate writes can be lost. busy covers held and in-flight words.

`timescale 1ns/1ps
`default_nettype none

module write_coalescer (
  input  logic                      src_clk,
  input  logic                      src_rst_n,
  input  logic                      wr_en,
  input  xfer_types_pkg::cfg_word_t wr_data,
  output logic                      busy,
  pulse_xfer_if.src                 xf
);

  xfer_ctrl_pkg::coalesce_state_t state_q;
  xfer_ctrl_pkg::coalesce_state_t state_d;
  logic                           launch_q;
  logic                           launch_d;
  logic                           store;
  xfer_types_pkg::cfg_word_t      word_q;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_d  = state_q;
    launch_d = 1'b0;
    store    = 1'b0;
    case (state_q)
      xfer_ctrl_pkg::CO_IDLE: begin
        // The previous transfer may still be closing its loop
        if (wr_en) begin
          store = 1'b1;
          if (xf.req_active) begin
            state_d = xfer_ctrl_pkg::CO_PEND;
          end else begin
            launch_d = 1'b1;
            state_d  = xfer_ctrl_pkg::CO_LAUNCHED;
          end
        end
      end
      xfer_ctrl_pkg::CO_LAUNCHED: begin
        // req_active shows up only after this cycle
        store   = wr_en;
        state_d = wr_en ? xfer_ctrl_pkg::CO_PEND : xfer_ctrl_pkg::CO_IDLE;
      end
      xfer_ctrl_pkg::CO_PEND: begin
        // A write in the launch cycle itself still wins over the held word
        store = wr_en;
        if (!xf.req_active) begin
          launch_d = 1'b1;
          state_d  = xfer_ctrl_pkg::CO_LAUNCHED;
        end
      end
      default: begin
        state_d = xfer_ctrl_pkg::CO_IDLE;
      end
    endcase
  end

  always_ff @(posedge src_clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      state_q  <= xfer_ctrl_pkg::CO_IDLE;
      launch_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      launch_q <= launch_d;
    end
  end

  // The crossing copies the word on acceptance, so this register may be
  // overwritten in the very cycle the strobe is taken
  always_ff @(posedge src_clk) begin
    if (store) begin
      word_q <= wr_data;
    end
  end

  assign xf.in_v    = launch_q;
  assign xf.in_data = word_q;
  assign busy       = (state_q != xfer_ctrl_pkg::CO_IDLE) | xf.req_active;

endmodule

`default_nettype wire

// ==== hdl/cfg_shadow_reg.sv ====
// Destination copy of the last delivered configuration word.
// cfg_update pulses for one dst_clk cycle together with the new cfg_value.

`timescale 1ns/1ps
`default_nettype none

module cfg_shadow_reg (
  input  logic                      dst_clk,
  input  logic                      dst_rst_n,
  pulse_xfer_if.dst                 xf,
  output xfer_types_pkg::cfg_word_t cfg_value,
  output logic                      cfg_update
);

  // ----------------------------------------
  // Capture
  // ----------------------------------------

  // Value and strobe are both registered, so downstream logic sees
  // them change in the same cycle
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      cfg_value  <= '0;
      cfg_update <= 1'b0;
    end else begin
      cfg_update <= xf.out_v;
      // out_data is only valid alongside out_v
      if (xf.out_v) begin
        cfg_value <= xf.out_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cfg_xfer_top.sv ====
// Carries configuration writes from src_clk into dst_clk.
// No back-pressure: under load older pending writes are replaced by newer ones.
// The newest write always arrives. SYNC_STAGES may be 2 or 3.

`timescale 1ns/1ps
`default_nettype none

module cfg_xfer_top #(
  parameter int SYNC_STAGES = xfer_ctrl_pkg::DEF_SYNC_STAGES
) (
  // Source clock domain
  input  logic                      src_clk,
  input  logic                      src_rst_n,
  input  logic                      wr_en,
  input  xfer_types_pkg::cfg_word_t wr_data,
  output logic                      busy,

  // Destination clock domain
  input  logic                      dst_clk,
  input  logic                      dst_rst_n,
  output xfer_types_pkg::cfg_word_t cfg_value,
  output logic                      cfg_update
);

  // ----------------------------------------
  // Crossing between the two halves
  // ----------------------------------------
  pulse_xfer_if xf ();

  // Source side, holds the newest write while a transfer runs
  write_coalescer u_coalescer (
    .src_clk   (src_clk),
    .src_rst_n (src_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .busy      (busy),
    .xf        (xf.src)
  );

  // Request/acknowledge loop
  pulse_xfer_reg #(.SYNC_STAGES(SYNC_STAGES)) u_xfer (
    .src_clk   (src_clk),
    .src_rst_n (src_rst_n),
    .dst_clk   (dst_clk),
    .dst_rst_n (dst_rst_n),
    .xf        (xf.xfer)
  );

  // Destination side, keeps the last delivered word
  cfg_shadow_reg u_shadow (
    .dst_clk    (dst_clk),
    .dst_rst_n  (dst_rst_n),
    .xf         (xf.dst),
    .cfg_value  (cfg_value),
    .cfg_update (cfg_update)
  );

endmodule

`default_nettype wire

// ==== bench/cfg_xfer_tb.sv ====
// Drives cfg_xfer_top from bench/cfg_xfer_stimulus.txt relative to the project root.
// Expected words come from the file. Update counts and write order come from the writes driven.
// Intermediate writes may be lost, so a burst only bounds the number of updates.

`timescale 1ns/1ps
`default_nettype none

module cfg_xfer_tb;

  localparam int    DST_PERIOD = 100;
  localparam int    SRC_HALF   = 35;
  localparam int    QUIET_CYC  = 10;
  localparam string STIM_FILE  = "bench/cfg_xfer_stimulus.txt";

  logic                      src_clk;
  logic                      src_rst_n;
  logic                      dst_clk;
  logic                      dst_rst_n;
  logic                      wr_en;
  xfer_types_pkg::cfg_word_t wr_data;
  logic                      busy;
  xfer_types_pkg::cfg_word_t cfg_value;
  logic                      cfg_update;

  // Parsed commands with one entry per W or C line
  byte                       cmd_kind[$];
  int                        cmd_gap[$];
  xfer_types_pkg::cfg_word_t cmd_word[$];
  bit                        cmds_loaded = 1'b0;

  // Every word driven so far in write order
  xfer_types_pkg::cfg_word_t written[$];
  int                        writes_since_check = 0;
  int                        last_match = -1;
  int                        updates_seen = 0;
  int                        updates_at_check = 0;
  xfer_types_pkg::cfg_word_t last_value = '0;

  cfg_xfer_top #(.SYNC_STAGES(xfer_ctrl_pkg::DEF_SYNC_STAGES)) DUT (
    .src_clk    (src_clk),
    .src_rst_n  (src_rst_n),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .busy       (busy),
    .dst_clk    (dst_clk),
    .dst_rst_n  (dst_rst_n),
    .cfg_value  (cfg_value),
    .cfg_update (cfg_update)
  );

  // The two clocks share no ratio, so edges drift against each other
  always #(DST_PERIOD / 2) dst_clk = ~dst_clk;
  always #(SRC_HALF) src_clk = ~src_clk;

  // ----------------------------------------
  // Checks and failure handling
  // ----------------------------------------
  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic compare_word(input string name, input xfer_types_pkg::cfg_word_t got,
                              input xfer_types_pkg::cfg_word_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // ----------------------------------------
  // Stimulus file
  // ----------------------------------------
  task automatic load_commands();
    int                        fd;
    int                        n;
    int                        gap;
    string                     line;
    xfer_types_pkg::cfg_word_t word;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %s", STIM_FILE);
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Comment lines start with # and blank lines are skipped
      if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
        if (line.getc(0) == "W" && $sscanf(line.substr(1, line.len() - 1), "%d %h",
                                           gap, word) == 2) begin
          cmd_kind.push_back("W");
          cmd_gap.push_back(gap);
          cmd_word.push_back(word);
        end else if (line.getc(0) == "C" &&
                     $sscanf(line.substr(1, line.len() - 1), "%h", word) == 1) begin
          cmd_kind.push_back("C");
          cmd_gap.push_back(0);
          cmd_word.push_back(word);
        end else begin
          $display("Stimulus line could not be parsed: %s", line);
          stop_with_failure();
        end
      end
    end
    $fclose(fd);
  endtask

  // Idles for the gap with wr_en low and then writes for one cycle. wr_en stays high
  // until the next command, so a gap of 0 gives back-to-back writes
  task automatic drive_write(input int gap, input xfer_types_pkg::cfg_word_t word);
    repeat (gap) begin
      @(posedge src_clk);
      wr_en <= 1'b0;
    end
    @(posedge src_clk);
    wr_en   <= 1'b1;
    wr_data <= word;
    written.push_back(word);
    writes_since_check++;
  endtask

  // Waits for busy to stay low, then checks the delivered state
  task automatic run_check(input xfer_types_pkg::cfg_word_t expected);
    int quiet;
    int n_upd;
    int lo;
    @(posedge src_clk);
    wr_en <= 1'b0;
    // The last write is taken on this edge, so a word is now held or in flight
    if (writes_since_check > 0) begin
      @(negedge src_clk);
      compare_flag("busy", busy, 1'b1);
    end
    quiet = 0;
    while (quiet < QUIET_CYC) begin
      @(negedge src_clk);
      if (busy === 1'b0) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    @(negedge dst_clk);
    compare_flag("cfg_update", cfg_update, 1'b0);
    compare_word("cfg_value", cfg_value, expected);
    n_upd = updates_seen - updates_at_check;
    if (writes_since_check > 0) begin
      compare_word("cfg_value vs last write", cfg_value, written[$]);
    end
    if (n_upd > 0) begin
      compare_word("last cfg_update value", last_value, expected);
    end
    // Each write delivers at most once, and at least one word arrives per batch
    lo = (writes_since_check > 0) ? 1 : 0;
    if (n_upd < lo || n_upd > writes_since_check) begin
      $display("Saw %0d updates for %0d writes since the previous check",
               n_upd, writes_since_check);
      stop_with_failure();
    end
    updates_at_check   = updates_seen;
    writes_since_check = 0;
  endtask

  // ----------------------------------------
  // Destination monitor
  // ----------------------------------------

  // A delivered word must match a write newer than the one matched before
  task automatic record_update(input xfer_types_pkg::cfg_word_t value);
    int idx;
    idx = last_match + 1;
    while (idx < written.size() && written[idx] !== value) begin
      idx++;
    end
    if (idx >= written.size()) begin
      $display("Delivered word 0x%08h is not a write newer than write %0d", value, last_match);
      stop_with_failure();
    end
    last_match = idx;
    last_value = value;
    updates_seen++;
  endtask

  // cfg_update is a full dst_clk cycle wide, so the falling edge sees it once
  always @(negedge dst_clk) begin
    if (cfg_update === 1'b1) begin
      record_update(cfg_value);
    end
  end

  // Budget of 60 dst_clk periods per command plus a margin for reset
  initial begin : watchdog
    int limit_ns;
    wait (cmds_loaded);
    limit_ns = (cmd_kind.size() + 4) * 60 * DST_PERIOD;
    #(limit_ns);
    $display("Timeout after %0d ns, the run did not complete", limit_ns);
    stop_with_failure();
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    src_clk   = 1'b0;
    dst_clk   = 1'b0;
    src_rst_n = 1'b0;
    dst_rst_n = 1'b0;
    wr_en     = 1'b0;
    wr_data   = '0;
    load_commands();
    cmds_loaded = 1'b1;
    repeat (2) @(posedge src_clk);
    src_rst_n <= 1'b1;
    repeat (2) @(posedge dst_clk);
    dst_rst_n <= 1'b1;
    // State right after reset
    @(negedge dst_clk);
    compare_flag("cfg_update", cfg_update, 1'b0);
    compare_flag("busy", busy, 1'b0);
    compare_word("cfg_value", cfg_value, '0);
    for (int i = 0; i < cmd_kind.size(); i++) begin
      if (cmd_kind[i] == "W") begin
        drive_write(cmd_gap[i], cmd_word[i]);
      end else begin
        run_check(cmd_word[i]);
      end
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/cfg_xfer_stimulus.txt ====
# W <gap in src_clk cycles before the write, decimal> <word, hex>
# C <expected cfg_value, hex>, taken once busy has stayed low
W 3 1234abcd
C 1234abcd
W 0 00000001
W 0 00000002
W 0 00000003
W 0 00000004
W 0 00000005
C 00000005
W 12 cafe0001
W 6 cafe0002
W 25 cafe0003
W 2 cafe0004
C cafe0004
C cafe0004
W 20 5a5a5a5a
C 5a5a5a5a
W 1 0f0f0f0f
W 1 f0f0f0f0
W 40 deadbeef
C deadbeef
W 0 00000000
C 00000000

// ==== build.f ====
common/xfer_types_pkg.sv
common/xfer_ctrl_pkg.sv
common/pulse_xfer_if.sv
hdl/sync_flops.sv
pulse_xfer/pulse_xfer_reg.sv
hdl/write_coalescer.sv
hdl/cfg_shadow_reg.sv
hdl/cfg_xfer_top.sv
bench/cfg_xfer_tb.sv

// ==== Makefile ====
# Verilator simulation of the configuration word crossing.
# Run from the project root. Variables may be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= cfg_xfer_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= >>> PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
